// File: hdl/mm_pkg.sv
/* Address map, data widths, vector types and the request target enum
   shared by the RAM and pseudo-peripheral block */
package mm_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH = DATA_WIDTH / 8;
  localparam int IRQ_ID_WIDTH = 5;

  // RAM region starts at address zero, 4 KiB
  localparam int RAM_ADDR_WIDTH = 12;
  localparam int RAM_WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [BE_WIDTH-1:0] be_t;
  typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;
  typedef logic [RAM_ADDR_WIDTH-3:0] ram_addr_t;

  // timer interrupt line, also the mask bit that enables it
  localparam irq_id_t TIMER_IRQ_ID = 5'd7;

  // timer registers
  localparam addr_t ADDR_TIMER_MASK = 32'h1500_0000;
  localparam addr_t ADDR_TIMER_CNT = 32'h1500_0004;
  // read-only, always returns zero
  localparam addr_t ADDR_TIMER_STAT = 32'h1500_1000;

  // test status and exit registers
  localparam addr_t ADDR_TEST_STATUS = 32'h2000_0000;
  localparam addr_t ADDR_EXIT = 32'h2000_0004;
  localparam addr_t ADDR_END_SIM = 32'h2000_0010;

  // values written to the status register
  localparam word_t TEST_PASS_CODE = 32'd123456789;
  localparam word_t TEST_FAIL_CODE = 32'd1;

  // where a request went, TGT_ERR when idle or unmapped
  typedef enum logic [1:0] {
    TGT_RAM    = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_ERR    = 2'd2
  } target_e;

endpackage

// File: hdl/mem_req_if.sv
/* Decoded single-cycle request from the bus controller to one target */
`timescale 1ns/1ps

interface mem_req_if;
  import mm_pkg::*;

  // strobe, one cycle per transaction, never refused
  logic  req;
  addr_t addr;
  logic  we;
  be_t   be;
  word_t wdata;

  modport ctrl(
    output req,
    output addr,
    output we,
    output be,
    output wdata
  );

  modport target(
    input req,
    input addr,
    input we,
    input be,
    input wdata
  );

endinterface

// File: hdl/mm_bus_ctrl.sv
/* Data port decoder with same-cycle grant, target register
   and one-cycle response path */
`timescale 1ns/1ps

module mm_bus_ctrl (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          data_req_i,
  input  logic          data_we_i,
  input  mm_pkg::addr_t data_addr_i,
  input  mm_pkg::be_t   data_be_i,
  input  mm_pkg::word_t data_wdata_i,
  output logic          data_gnt_o,
  output logic          data_rvalid_o,
  output mm_pkg::word_t data_rdata_o,

  input  mm_pkg::word_t ram_rdata_i,

  mem_req_if.ctrl       ram_req,
  mem_req_if.ctrl       per_req
);
  import mm_pkg::*;

  target_e tgt_d;
  target_e tgt_q;
  logic    we_q;
  logic    ram_hit;
  logic    per_wr_hit;
  logic    per_rd_hit;

  // RAM sits at the bottom of the address space
  assign ram_hit = (data_addr_i[ADDR_WIDTH-1:RAM_ADDR_WIDTH] == '0);

  // peripheral registers, writes and reads have separate maps
  assign per_wr_hit = (data_addr_i == ADDR_TIMER_MASK) ||
                      (data_addr_i == ADDR_TIMER_CNT) ||
                      (data_addr_i == ADDR_TEST_STATUS) ||
                      (data_addr_i == ADDR_EXIT) ||
                      (data_addr_i == ADDR_END_SIM);
  assign per_rd_hit = (data_addr_i == ADDR_TIMER_STAT);

  always_comb begin
    tgt_d = TGT_ERR;
    if (data_req_i) begin
      if (ram_hit) begin
        tgt_d = TGT_RAM;
      end else if (data_we_i ? per_wr_hit : per_rd_hit) begin
        tgt_d = TGT_PERIPH;
      end
    end
  end

  // grant whenever the request lands somewhere, no stalls
  assign data_gnt_o = (tgt_d != TGT_ERR);

  assign ram_req.req   = (tgt_d == TGT_RAM);
  assign ram_req.addr  = data_addr_i;
  assign ram_req.we    = data_we_i;
  assign ram_req.be    = data_be_i;
  assign ram_req.wdata = data_wdata_i;

  assign per_req.req   = (tgt_d == TGT_PERIPH);
  assign per_req.addr  = data_addr_i;
  assign per_req.we    = data_we_i;
  assign per_req.be    = data_be_i;
  assign per_req.wdata = data_wdata_i;

  // remember where the granted request went, TGT_ERR means no response due
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q <= TGT_ERR;
      we_q  <= 1'b0;
    end else begin
      tgt_q <= tgt_d;
      we_q  <= data_we_i;
    end
  end

  assign data_rvalid_o = (tgt_q != TGT_ERR);

  // only RAM reads return data, everything else answers zero
  assign data_rdata_o = (tgt_q == TGT_RAM && !we_q) ? ram_rdata_i : '0;

endmodule

// File: hdl/mm_ram.sv
/* Word-organised synchronous RAM with per-byte write enables */
`timescale 1ns/1ps

module mm_ram (
  input  logic          clk_i,
  mem_req_if.target     req,
  output mm_pkg::word_t rdata_o
);
  import mm_pkg::*;

  word_t     mem [RAM_WORDS];
  ram_addr_t widx;

  // byte address to word index, upper bits already decoded away
  assign widx = req.addr[RAM_ADDR_WIDTH-1:2];

  // write under byte enables, read data appears the cycle after
  always_ff @(posedge clk_i) begin
    if (req.req) begin
      if (req.we) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (req.be[i]) begin
            mem[widx][8*i +: 8] <= req.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[widx];
      end
    end
  end

endmodule

// File: hdl/mm_periph.sv
/* Countdown timer with maskable interrupt, test pass/fail flags
   and exit value outputs */
`timescale 1ns/1ps

module mm_periph (
  input  logic            clk_i,
  input  logic            rst_ni,
  mem_req_if.target       req,

  input  mm_pkg::irq_id_t irq_id_i,
  input  logic            irq_ack_i,
  output logic            irq_timer_o,

  output logic            tests_passed_o,
  output logic            tests_failed_o,
  output logic            exit_valid_o,
  output mm_pkg::word_t   exit_value_o
);
  import mm_pkg::*;

  logic  wr;
  logic  mask_wr;
  logic  cnt_wr;
  logic  status_wr;
  logic  exit_wr;
  logic  end_sim_wr;
  logic  timer_ack;
  word_t mask_q;
  word_t cnt_q;
  logic  irq_q;

  // only writes change state here, the status read just needs a response
  assign wr         = req.req && req.we;
  assign mask_wr    = wr && (req.addr == ADDR_TIMER_MASK);
  assign cnt_wr     = wr && (req.addr == ADDR_TIMER_CNT);
  assign status_wr  = wr && (req.addr == ADDR_TEST_STATUS);
  assign exit_wr    = wr && (req.addr == ADDR_EXIT);
  assign end_sim_wr = wr && (req.addr == ADDR_END_SIM);

  assign timer_ack = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

  // countdown pauses in cycles that write a timer register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
      cnt_q  <= '0;
      irq_q  <= 1'b0;
    end else if (mask_wr) begin
      mask_q <= req.wdata;
    end else if (cnt_wr) begin
      cnt_q <= req.wdata;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // fires on the 1 -> 0 step
      if (cnt_q == word_t'(1) && mask_q[TIMER_IRQ_ID]) begin
        irq_q <= 1'b1;
      end
      // acknowledge has priority over a new expiry
      if (timer_ack) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign irq_timer_o = irq_q;

  // status and exit flags are strobes in the write cycle itself
  assign tests_passed_o = status_wr && (req.wdata == TEST_PASS_CODE);
  assign tests_failed_o = status_wr && (req.wdata == TEST_FAIL_CODE);
  assign exit_valid_o   = exit_wr || end_sim_wr;
  // end-of-simulation reports a clean exit
  assign exit_value_o   = exit_wr ? req.wdata : '0;

endmodule

// File: hdl/mm_ram_top.sv
/* Top level of the data-port RAM and pseudo-peripheral block,
   bus controller, RAM and peripheral instances */
`timescale 1ns/1ps

module mm_ram_top (
  input  logic            clk_i,
  input  logic            rst_ni,

  // data port, request/grant/rvalid
  input  logic            data_req_i,
  input  logic            data_we_i,
  input  mm_pkg::addr_t   data_addr_i,
  input  mm_pkg::be_t     data_be_i,
  input  mm_pkg::word_t   data_wdata_i,
  output logic            data_gnt_o,
  output logic            data_rvalid_o,
  output mm_pkg::word_t   data_rdata_o,

  // interrupt
  input  mm_pkg::irq_id_t irq_id_i,
  input  logic            irq_ack_i,
  output logic            irq_timer_o,

  // test status
  output logic            tests_passed_o,
  output logic            tests_failed_o,
  output logic            exit_valid_o,
  output mm_pkg::word_t   exit_value_o
);
  import mm_pkg::*;

  word_t ram_rdata;

  mem_req_if ram_req ();
  mem_req_if per_req ();

  mm_bus_ctrl u_bus_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .data_we_i    (data_we_i),
    .data_addr_i  (data_addr_i),
    .data_be_i    (data_be_i),
    .data_wdata_i (data_wdata_i),
    .data_gnt_o   (data_gnt_o),
    .data_rvalid_o(data_rvalid_o),
    .data_rdata_o (data_rdata_o),
    .ram_rdata_i  (ram_rdata),
    .ram_req      (ram_req.ctrl),
    .per_req      (per_req.ctrl)
  );

  mm_ram u_ram (
    .clk_i  (clk_i),
    .req    (ram_req.target),
    .rdata_o(ram_rdata)
  );

  mm_periph u_periph (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req           (per_req.target),
    .irq_id_i      (irq_id_i),
    .irq_ack_i     (irq_ack_i),
    .irq_timer_o   (irq_timer_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

endmodule

// File: tests/mm_bus_properties.sv
/* Handshake assertions for the bus controller, bound into mm_bus_ctrl */
`timescale 1ns/1ps

module mm_bus_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic ram_req_i,
  input logic per_req_i
);

  // every grant gets exactly one response in the next cycle
  a_rvalid_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) gnt_i |=> rvalid_i
  ) else $error("rvalid missing one cycle after grant");

  a_rvalid_needs_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) rvalid_i |-> $past(gnt_i)
  ) else $error("rvalid without a grant in the previous cycle");

  a_gnt_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_i
  ) else $error("grant without a request");

  // at most one target sees a request
  a_one_target: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(ram_req_i && per_req_i)
  ) else $error("RAM and peripheral strobes high together");

endmodule

bind mm_bus_ctrl mm_bus_properties u_bus_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .req_i    (data_req_i),
  .gnt_i    (data_gnt_o),
  .rvalid_i (data_rvalid_o),
  .ram_req_i(ram_req.req),
  .per_req_i(per_req.req)
);

// File: tests/tb_mm_ram.sv
/* Testbench for the data-port RAM and peripheral block: stimulus table, checker,
   status and exit writes, back-to-back requests and timer interrupt test */
`timescale 1ns/1ps

module tb_mm_ram;
  import mm_pkg::*;

  typedef struct {
    logic  we;
    addr_t addr;
    be_t   be;
    word_t wdata;
    logic  gnt;
    word_t rdata;
  } entry_t;

  logic    clk_i = 1'b0;
  logic    rst_ni = 1'b0;
  logic    data_req_i = 1'b0;
  logic    data_we_i = 1'b0;
  addr_t   data_addr_i = '0;
  be_t     data_be_i = '0;
  word_t   data_wdata_i = '0;
  irq_id_t irq_id_i = '0;
  logic    irq_ack_i = 1'b0;
  logic    data_gnt_o;
  logic    data_rvalid_o;
  word_t   data_rdata_o;
  logic    irq_timer_o;
  logic    tests_passed_o;
  logic    tests_failed_o;
  logic    exit_valid_o;
  word_t   exit_value_o;

  entry_t  table_q [$];
  // reference copy of the RAM contents
  word_t   model [RAM_WORDS];

  mm_ram_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_addr_i   (data_addr_i),
    .data_be_i     (data_be_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .irq_id_i      (irq_id_i),
    .irq_ack_i     (irq_ack_i),
    .irq_timer_o   (irq_timer_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic addr_t word_addr(input int w);
    return addr_t'(w) << 2;
  endfunction

  function automatic ram_addr_t word_index(input addr_t addr);
    return addr[RAM_ADDR_WIDTH-1:2];
  endfunction

  function automatic void model_write(input addr_t addr, input be_t be, input word_t wdata);
    int b;
    for (b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        model[word_index(addr)][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  function automatic void push_entry(input logic we, input addr_t addr, input be_t be,
                                     input word_t wdata, input logic gnt, input word_t rdata);
    entry_t e;
    e.we    = we;
    e.addr  = addr;
    e.be    = be;
    e.wdata = wdata;
    e.gnt   = gnt;
    e.rdata = rdata;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    int    words [4];
    be_t   partial [4];
    int    i;
    addr_t unmapped;
    unmapped   = addr_t'(1) << RAM_ADDR_WIDTH;
    words[0]   = 0;
    words[1]   = 1;
    words[2]   = 37;
    words[3]   = RAM_WORDS - 1;
    partial[0] = 4'b1010;
    partial[1] = 4'b0001;
    partial[2] = 4'b0110;
    partial[3] = 4'b1000;
    // full words first so every byte is known
    for (i = 0; i < 4; i++) begin
      model_write(word_addr(words[i]), '1, $urandom);
      push_entry(1'b1, word_addr(words[i]), '1, model[word_index(word_addr(words[i]))],
                 1'b1, '0);
    end
    for (i = 0; i < 8; i++) begin
      if (i == 4) begin
        push_entry(1'b1, word_addr(words[0]), partial[0], $urandom, 1'b1, '0);
        model_write(word_addr(words[0]), partial[0], table_q[table_q.size()-1].wdata);
      end
      push_entry(1'b0, word_addr(words[i % 4]), '1, '0, 1'b1,
                 model[word_index(word_addr(words[i % 4]))]);
    end
    // remaining partial writes, each followed by a read
    for (i = 1; i < 4; i++) begin
      push_entry(1'b1, word_addr(words[i]), partial[i], $urandom, 1'b1, '0);
      model_write(word_addr(words[i]), partial[i], table_q[table_q.size()-1].wdata);
      push_entry(1'b0, word_addr(words[i]), '1, '0, 1'b1, model[word_index(word_addr(words[i]))]);
    end
    push_entry(1'b0, ADDR_TIMER_STAT, '1, '0, 1'b1, '0);
    push_entry(1'b0, unmapped, '1, '0, 1'b0, '0);
    push_entry(1'b1, unmapped + 32'd4, '1, 32'h1234_5678, 1'b0, '0);
    push_entry(1'b1, ADDR_TIMER_STAT, '1, 32'h0000_00ff, 1'b0, '0);
    push_entry(1'b0, ADDR_EXIT, '1, '0, 1'b0, '0);
  endfunction

  task automatic drive_request(input logic we, input addr_t addr, input be_t be,
                               input word_t wdata);
    @(posedge clk_i);
    data_req_i   <= 1'b1;
    data_we_i    <= we;
    data_addr_i  <= addr;
    data_be_i    <= be;
    data_wdata_i <= wdata;
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    data_req_i <= 1'b0;
    data_we_i  <= 1'b0;
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!data_rvalid_o && cycles < 8) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!data_rvalid_o) begin
      abort_run("no response within 8 cycles of a granted request");
    end
  endtask

  task automatic check_no_response();
    int cycles;
    for (cycles = 0; cycles < 8; cycles++) begin
      @(negedge clk_i);
      if (data_rvalid_o) begin
        abort_run("a response arrived for a request that was not granted");
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    drive_request(e.we, e.addr, e.be, e.wdata);
    @(negedge clk_i);
    check_value("data_gnt_o", word_t'(data_gnt_o), word_t'(e.gnt));
    go_idle();
    if (e.gnt) begin
      wait_response();
      check_value("data_rdata_o", data_rdata_o, e.rdata);
    end else begin
      check_no_response();
    end
  endtask

  // flags are only valid in the request cycle
  task automatic write_periph(input addr_t addr, input word_t wdata, input logic passed,
                              input logic failed, input logic exit_valid, input word_t exit_value);
    drive_request(1'b1, addr, '1, wdata);
    @(negedge clk_i);
    check_value("data_gnt_o", word_t'(data_gnt_o), 32'd1);
    check_value("tests_passed_o", word_t'(tests_passed_o), word_t'(passed));
    check_value("tests_failed_o", word_t'(tests_failed_o), word_t'(failed));
    check_value("exit_valid_o", word_t'(exit_valid_o), word_t'(exit_valid));
    if (exit_valid) begin
      check_value("exit_value_o", exit_value_o, exit_value);
    end
    go_idle();
    wait_response();
    check_value("data_rdata_o", data_rdata_o, '0);
    check_value("exit_valid_o", word_t'(exit_valid_o), '0);
  endtask

  task automatic run_back_to_back();
    logic  we_seq [4];
    addr_t addr_seq [4];
    word_t data_seq [4];
    word_t exp_seq [4];
    int    i;
    for (i = 0; i < 4; i++) begin
      we_seq[i]   = (i < 2);
      addr_seq[i] = word_addr(10 + i % 2);
      data_seq[i] = $urandom;
      if (we_seq[i]) begin
        model_write(addr_seq[i], '1, data_seq[i]);
      end
      exp_seq[i] = we_seq[i] ? '0 : model[word_index(addr_seq[i])];
    end
    // a new request every cycle, responses overlap the next request
    for (i = 0; i < 6; i++) begin
      if (i < 4) begin
        drive_request(we_seq[i], addr_seq[i], '1, data_seq[i]);
      end else begin
        go_idle();
      end
      @(negedge clk_i);
      if (i < 4) begin
        check_value("data_gnt_o", word_t'(data_gnt_o), 32'd1);
      end
      if (i >= 1 && i <= 4) begin
        check_value("data_rvalid_o", word_t'(data_rvalid_o), 32'd1);
        check_value("data_rdata_o", data_rdata_o, exp_seq[i-1]);
      end else begin
        check_value("data_rvalid_o", word_t'(data_rvalid_o), '0);
      end
    end
  endtask

  task automatic run_timer(input int n, input logic enabled);
    int k;
    write_periph(ADDR_TIMER_MASK, enabled ? (word_t'(1) << TIMER_IRQ_ID) : '0, 0, 0, 0, '0);
    write_periph(ADDR_TIMER_CNT, word_t'(n), 0, 0, 0, '0);
    // now one cycle past the write edge
    check_value("irq_timer_o", word_t'(irq_timer_o), '0);
    for (k = 2; k <= n; k++) begin
      @(negedge clk_i);
      check_value("irq_timer_o", word_t'(irq_timer_o), '0);
    end
    @(negedge clk_i);
    check_value("irq_timer_o", word_t'(irq_timer_o), word_t'(enabled));
    if (enabled) begin
      // another id must not clear the timer interrupt
      @(posedge clk_i);
      irq_ack_i <= 1'b1;
      irq_id_i  <= 5'd3;
      @(posedge clk_i);
      irq_id_i  <= TIMER_IRQ_ID;
      @(negedge clk_i);
      check_value("irq_timer_o", word_t'(irq_timer_o), 32'd1);
      @(posedge clk_i);
      irq_ack_i <= 1'b0;
      @(negedge clk_i);
      check_value("irq_timer_o", word_t'(irq_timer_o), '0);
    end
  endtask

  initial begin
    int n;
    void'($urandom(32'hd6c0));
    build_table();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("data_rvalid_o", word_t'(data_rvalid_o), '0);
    check_value("irq_timer_o", word_t'(irq_timer_o), '0);
    foreach (table_q[i]) begin
      apply_entry(table_q[i]);
    end
    write_periph(ADDR_TEST_STATUS, TEST_PASS_CODE, 1, 0, 0, '0);
    write_periph(ADDR_TEST_STATUS, TEST_FAIL_CODE, 0, 1, 0, '0);
    write_periph(ADDR_TEST_STATUS, 32'h0000_5a5a, 0, 0, 0, '0);
    write_periph(ADDR_EXIT, 32'h0000_002a, 0, 0, 1, 32'h0000_002a);
    write_periph(ADDR_END_SIM, 32'hdead_beef, 0, 0, 1, '0);
    run_back_to_back();
    n = 3 + int'($urandom % 38);
    run_timer(n, 1'b1);
    run_timer(n, 1'b0);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: flist.f
hdl/mm_pkg.sv
hdl/mem_req_if.sv
hdl/mm_bus_ctrl.sv
hdl/mm_ram.sv
hdl/mm_periph.sv
hdl/mm_ram_top.sv
tests/mm_bus_properties.sv
tests/tb_mm_ram.sv

// File: Makefile
# Verilator build, run, lint and clean for the data-port RAM block

VERILATOR  ?= verilator
TOP        ?= tb_mm_ram
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert

PASS_MSG := *** TEST PASSED ***
SIM      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# pass only if the testbench printed the pass message
run: build
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
